/* reprog_defines.svh */
`ifndef REPROG_DEFINES_SVH
`define REPROG_DEFINES_SVH

// ===========================================================================
// configuration command words, logical bit order
// ===========================================================================

`define ICAP_DUMMY_WORD   32'hFFFF_FFFF // bus width detect padding
`define ICAP_SYNC_WORD    32'hAA99_5566 // sync pattern
`define ICAP_NO_OP        32'h2000_0000 // type 1 no-op
`define ICAP_WRITE_WBSTAR 32'h3002_0001 // type 1 write, 1 word to WBSTAR
`define ICAP_WRITE_CMD    32'h3000_8001 // type 1 write, 1 word to CMD
`define ICAP_IPROG        32'h0000_000F // IPROG command code

// ===========================================================================
// flash start addresses of the two images
// ===========================================================================

`define GOLDEN_FLASH_ADDR 24'h00_0000 // fallback image at bottom of flash
`define MASTER_FLASH_ADDR 24'h40_0000 // regular image, upper half

// ===========================================================================
// command buffer
// ===========================================================================

// kept below the 8-word sequence so full can stall the sequencer
`define CMD_FIFO_DEPTH 4

`endif

/* icap_pkg.sv */
`default_nettype none

// configuration port side types
package icap_pkg;

	// 32-bit configuration word, logical bit order
	typedef logic [31:0] cfg_word_t;

	// port bus as presented to the configuration access port
	typedef struct packed {
		logic      csib; // active-low enable
		cfg_word_t data; // bytes bit-reversed, port order
	} icap_bus_t;

endpackage

`default_nettype wire

/* reprog_pkg.sv */
`default_nettype none

// reprogram control types
package reprog_pkg;

	typedef logic [23:0] flash_addr_t; // flash byte address

	// image chosen by the trigger
	typedef enum logic {
		IMAGE_GOLDEN = 1'b0,
		IMAGE_MASTER = 1'b1
	} image_sel_t;

	// command sequencer states
	typedef enum logic [3:0] {
		IDLE       = 4'd0,
		SEND_WORD1 = 4'd1, // dummy
		SEND_WORD2 = 4'd2, // sync
		SEND_WORD3 = 4'd3, // no-op
		SEND_WORD4 = 4'd4, // write WBSTAR
		SEND_WORD5 = 4'd5, // flash address
		SEND_WORD6 = 4'd6, // write CMD
		SEND_WORD7 = 4'd7, // IPROG
		SEND_WORD8 = 4'd8, // trailing no-op
		DONE       = 4'd9
	} seq_state_t;

endpackage

`default_nettype wire

/* reprog_sequencer.sv */
`default_nettype none

`include "reprog_defines.svh"

module reprog_sequencer
	import icap_pkg::*, reprog_pkg::*;
(
	input  wire logic       clk,
	input  wire logic       reset,
	input  wire logic [1:0] trigger,   // [0] golden, [1] master
	input  wire logic       full,
	output logic            push,
	output cfg_word_t       push_word,
	output logic            done
);

// ===========================================================================
// state and image latch
// ===========================================================================

seq_state_t  state;
seq_state_t  state_next;
image_sel_t  image_sel;      // valid once out of IDLE
flash_addr_t flash_addr;

assign flash_addr = (image_sel == IMAGE_GOLDEN) ? `GOLDEN_FLASH_ADDR : `MASTER_FLASH_ADDR;

assign push = (state != IDLE) && (state != DONE) && !full; // only sending states push
assign done = (state == DONE);

always_ff @(posedge clk) begin
	if (reset) begin
		state <= IDLE;
	end else begin
		state <= state_next;
	end
end

always_ff @(posedge clk) begin
	if (state == IDLE) begin
		if (trigger[0]) begin
			image_sel <= IMAGE_GOLDEN; // golden wins when both set
		end else if (trigger[1]) begin
			image_sel <= IMAGE_MASTER;
		end
	end
end

// ===========================================================================
// word select and next state
// ===========================================================================

always_comb begin
	state_next = state;
	push_word  = `ICAP_NO_OP; // IDLE and DONE, never pushed
	case (state)
		IDLE: begin
			if (trigger[0] || trigger[1]) state_next = SEND_WORD1;
		end
		SEND_WORD1: begin
			push_word = `ICAP_DUMMY_WORD;
			if (push) state_next = SEND_WORD2;
		end
		SEND_WORD2: begin
			push_word = `ICAP_SYNC_WORD;
			if (push) state_next = SEND_WORD3;
		end
		SEND_WORD3: begin
			push_word = `ICAP_NO_OP;
			if (push) state_next = SEND_WORD4;
		end
		SEND_WORD4: begin
			push_word = `ICAP_WRITE_WBSTAR;
			if (push) state_next = SEND_WORD5;
		end
		SEND_WORD5: begin
			push_word = {8'h00, flash_addr}; // upper byte zero
			if (push) state_next = SEND_WORD6;
		end
		SEND_WORD6: begin
			push_word = `ICAP_WRITE_CMD;
			if (push) state_next = SEND_WORD7;
		end
		SEND_WORD7: begin
			push_word = `ICAP_IPROG;
			if (push) state_next = SEND_WORD8;
		end
		SEND_WORD8: begin
			push_word = `ICAP_NO_OP;
			if (push) state_next = DONE;
		end
		default: begin
			state_next = DONE; // parked, device reconfigures from here
		end
	endcase
end

// done is sticky until reset, triggers after the sequence are ignored
assert property (@(posedge clk) disable iff (reset) done |=> done)
	else $error("sequencer left DONE without reset");

endmodule

`default_nettype wire

/* cmd_fifo.sv */
`default_nettype none

`include "reprog_defines.svh"

module cmd_fifo
	import icap_pkg::*;
(
	input  wire logic      clk,
	input  wire logic      reset,
	input  wire logic      push,
	input  cfg_word_t      push_word,
	input  wire logic      pop,
	output cfg_word_t      head_word,  // valid while empty is low
	output logic           full,
	output logic           empty
);

localparam int DEPTH = `CMD_FIFO_DEPTH;
localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int CNT_W = $clog2(DEPTH + 1);

// ===========================================================================
// storage and pointers
// ===========================================================================

cfg_word_t        mem [DEPTH];
logic [PTR_W-1:0] wr_ptr;
logic [PTR_W-1:0] rd_ptr;
logic [CNT_W-1:0] count;   // occupied entries

assign full      = (count == CNT_W'(DEPTH));
assign empty     = (count == '0);
assign head_word = mem[rd_ptr]; // no read latency

always_ff @(posedge clk) begin
	if (push) begin
		mem[wr_ptr] <= push_word;
	end
end

always_ff @(posedge clk) begin
	if (reset) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count  <= '0;
	end else begin
		if (push) begin
			wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // wrap
		end
		if (pop) begin
			rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
		end
		case ({push, pop})
			2'b10:   count <= count + 1'b1;
			2'b01:   count <= count - 1'b1;
			default: count <= count;     // both or neither, level unchanged
		endcase
	end
end

// ===========================================================================
// checks
// ===========================================================================

assert property (@(posedge clk) disable iff (reset) push |-> !full)
	else $error("FIFO overflow");

assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
	else $error("FIFO underflow");

endmodule

`default_nettype wire

/* icap_writer.sv */
`default_nettype none

`include "reprog_defines.svh"

module icap_writer
	import icap_pkg::*;
(
	input  wire logic clk,
	input  wire logic reset,
	input  cfg_word_t head_word,
	input  wire logic empty,
	input  wire logic hold,      // port busy, stop draining
	output logic      pop,
	output icap_bus_t icap_bus
);

// reverse bit order inside each byte, byte order kept
function automatic cfg_word_t byte_bitrev(input cfg_word_t w);
	cfg_word_t r;
	for (int b = 0; b < 4; b++) begin
		for (int i = 0; i < 8; i++) begin
			r[8*b + i] = w[8*b + 7 - i];
		end
	end
	return r;
endfunction

// ===========================================================================
// drain and register port bus
// ===========================================================================

assign pop = !empty && !hold;

always_ff @(posedge clk) begin
	if (reset) begin
		icap_bus.csib <= 1'b1;                     // disabled
		icap_bus.data <= byte_bitrev(`ICAP_NO_OP);
	end else if (pop) begin
		icap_bus.csib <= 1'b0;                     // enabled for this word
		icap_bus.data <= byte_bitrev(head_word);
	end else begin
		icap_bus.csib <= 1'b1;                     // idle
		icap_bus.data <= byte_bitrev(`ICAP_NO_OP);
	end
end

endmodule

`default_nettype wire

/* reprog_top.sv */
`default_nettype none

module reprog_top
	import icap_pkg::*;
(
	input  wire logic       clk,
	input  wire logic       reset,
	input  wire logic [1:0] trigger,  // [0] golden, [1] master
	input  wire logic       hold,
	output icap_bus_t       icap_bus,
	output logic            done
);

// sequencer to FIFO
logic      push;
cfg_word_t push_word;
logic      full;

// FIFO to writer
cfg_word_t head_word;
logic      empty;
logic      pop;

reprog_sequencer u_sequencer (
	.clk       (clk),
	.reset     (reset),
	.trigger   (trigger),
	.full      (full),
	.push      (push),
	.push_word (push_word),
	.done      (done)
);

cmd_fifo u_fifo (
	.clk       (clk),
	.reset     (reset),
	.push      (push),
	.push_word (push_word),
	.pop       (pop),
	.head_word (head_word),
	.full      (full),
	.empty     (empty)
);

icap_writer u_writer (
	.clk       (clk),
	.reset     (reset),
	.head_word (head_word),
	.empty     (empty),
	.hold      (hold),
	.pop       (pop),
	.icap_bus  (icap_bus)
);

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`default_nettype none

// free running testbench clock
module tb_clock_gen #(
	parameter int HALF_PERIOD = 2 // period 4
) (
	output logic clk
);

initial begin
	clk = 1'b0;
end

always begin
	#HALF_PERIOD clk = ~clk;
end

endmodule

`default_nettype wire

/* reprog_tb.sv */
`default_nettype none

`include "reprog_defines.svh"

module reprog_tb
	import icap_pkg::*, reprog_pkg::*;
;

// 5 tests of about 20 cycles, margin for hold patterns
localparam int TEST_COUNT      = 5;
localparam int CYCLES_PER_TEST = 20;
localparam int MAX_CYCLES      = TEST_COUNT * CYCLES_PER_TEST * 4;
localparam int WORD_WAIT_LIMIT = 80; // per sequence, hold at 75% busy

logic       clk;
logic       reset;
logic [1:0] trigger;
logic       hold;
icap_bus_t  icap_bus;
logic       done;

image_sel_t exp_image;  // image the compare process expects
int         word_count; // enabled words seen since reset
logic       saw_full;   // sequencer stalled by FIFO since reset
int         cycles;

tb_clock_gen clock_gen (.clk(clk));

reprog_top uut (
	.clk      (clk),
	.reset    (reset),
	.trigger  (trigger),
	.hold     (hold),
	.icap_bus (icap_bus),
	.done     (done)
);

// ===========================================================================
// reference model and reporting
// ===========================================================================

// expected port word: logical command word, bits mirrored inside each byte
function automatic cfg_word_t expected_port_word(input image_sel_t img, input int idx);
	cfg_word_t   logical;
	cfg_word_t   port;
	flash_addr_t addr;
	addr = (img == IMAGE_MASTER) ? `MASTER_FLASH_ADDR : `GOLDEN_FLASH_ADDR;
	case (idx)
		0:       logical = `ICAP_DUMMY_WORD;
		1:       logical = `ICAP_SYNC_WORD;
		2:       logical = `ICAP_NO_OP;
		3:       logical = `ICAP_WRITE_WBSTAR;
		4:       logical = {8'h00, addr}; // WBSTAR payload
		5:       logical = `ICAP_WRITE_CMD;
		6:       logical = `ICAP_IPROG;
		default: logical = `ICAP_NO_OP;   // trailing no-op
	endcase
	for (int i = 0; i < 32; i++) begin
		port[i] = logical[(i / 8) * 8 + 7 - (i % 8)];
	end
	return port;
endfunction

task automatic stop_run(input string why);
	$display("%s", why);
	$display("Something failed");
	$fatal(1, "simulation stopped");
endtask

task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp) begin
		stop_run($sformatf("Mismatch at %0t: %s got %08h expected %08h", $time, what, got, exp));
	end
endtask

// ===========================================================================
// compare process and timeout
// ===========================================================================

always @(posedge clk) begin
	if (reset) begin
		word_count = 0;
		saw_full   = 1'b0;
	end else begin
		if (!icap_bus.csib) begin // enabled word on the port
			if (word_count >= 8) begin
				stop_run("too many words on the port bus");
			end else begin
				check_value($sformatf("port word %0d", word_count), icap_bus.data,
					expected_port_word(exp_image, word_count));
				word_count = word_count + 1;
			end
		end else begin
			// idle bus carries the mirrored no-op
			check_value("idle port data", icap_bus.data, expected_port_word(exp_image, 7));
		end
		if (uut.full) saw_full = 1'b1;
	end
end

always @(posedge clk) begin
	cycles = cycles + 1;
	if (cycles >= MAX_CYCLES) stop_run("timeout, run exceeded the cycle limit");
end

// ===========================================================================
// stimulus, all on the falling edge
// ===========================================================================

// caller sits at a falling edge
task automatic apply_reset();
	reset = 1'b1;
	repeat (3) @(negedge clk);
	reset = 1'b0;
	check_value("csib after reset", 32'(icap_bus.csib), 32'd1);
	check_value("done after reset", 32'(done), 32'd0);
	check_value("fifo empty after reset", 32'(uut.empty), 32'd1);
endtask

// one-cycle trigger pulse, then wait for n words
task automatic wait_for_words(input logic [1:0] trig, input int n, input logic random_hold);
	int waited;
	waited  = 0;
	trigger = trig;
	@(negedge clk);
	trigger = 2'b00;
	while (word_count < n) begin
		hold = random_hold ? ($urandom % 4 != 0) : 1'b0; // mostly busy when random
		@(negedge clk);
		waited = waited + 1;
		if (waited > WORD_WAIT_LIMIT) begin
			stop_run($sformatf("too few words, only %0d of %0d arrived", word_count, n));
		end
	end
	hold = 1'b0;
endtask

task automatic run_sequence(input logic [1:0] trig, input image_sel_t img, input logic random_hold);
	exp_image = img;
	wait_for_words(trig, 8, random_hold);
	repeat (6) @(negedge clk); // extra words would show up here
	if (!done) stop_run("done did not rise after the sequence");
	check_value("csib after sequence", 32'(icap_bus.csib), 32'd1);
endtask

initial begin
	void'($urandom(27505));
	reset     = 1'b1;
	trigger   = 2'b00;
	hold      = 1'b0;
	exp_image = IMAGE_GOLDEN;
	cycles    = 0;
	@(negedge clk);
	apply_reset();

	run_sequence(2'b01, IMAGE_GOLDEN, 1'b0); // golden
	apply_reset();
	run_sequence(2'b10, IMAGE_MASTER, 1'b0); // master address in word five
	apply_reset();
	run_sequence(2'b11, IMAGE_GOLDEN, 1'b0); // golden wins
	apply_reset();
	run_sequence(2'b10, IMAGE_MASTER, 1'b1); // random hold
	if (!saw_full) stop_run("FIFO never filled under random hold");

	// retrigger after done is ignored
	trigger = 2'b10;
	@(negedge clk);
	trigger = 2'b00;
	repeat (10) @(negedge clk);
	check_value("word count after retrigger", 32'(word_count), 32'd8);
	if (!done) stop_run("done dropped after a retrigger");

	// reset in the middle of a sequence, then a fresh one
	apply_reset();
	exp_image = IMAGE_GOLDEN;
	wait_for_words(2'b01, 3, 1'b0);
	apply_reset();
	run_sequence(2'b10, IMAGE_MASTER, 1'b0);

	$display("Everything OK");
	$finish;
end

endmodule

`default_nettype wire

/* build.f */
+incdir+.
icap_pkg.sv
reprog_pkg.sv
reprog_sequencer.sv
cmd_fifo.sv
icap_writer.sv
reprog_top.sv
tb_clock_gen.sv
reprog_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the reprogram subsystem testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert \
	--top-module reprog_tb \
	-f build.f \
	-o reprog_sim; then
	echo "verilator build error"
	exit 1
fi

if ! ./obj_dir/reprog_sim; then
	echo "simulation returned an error status"
	exit 1
fi

exit 0
